// File: div_ctrl.sv
// ==========================================================================
// divide control: IDLE/DO_DIV/FINISH FSM, step counter, held operation
// flags and the result register
// ==========================================================================
`timescale 1ns/1ps
`include "div_defs.svh"

module div_ctrl
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      div_valid_i,
  input  logic      result_ready_i,
  input  div_prep_t prep_i,
  input  xlen_t     fix_result_i,
  output logic      load_o,
  output logic      step_o,
  output div_prep_t held_o,
  output xlen_t     result_o,
  output logic      result_ok_o,
  output logic      busy_o
);

  div_state_e state_q;
  div_state_e state_d;
  cnt_t       cnt_q;
  xlen_t      result_q;
  div_prep_t  held_q;
  div_prep_t  held_d;
  logic       accept;

  // ==========================================================================
  // next state
  // ==========================================================================
  assign accept = (state_q == IDLE) && div_valid_i;   // valid ignored elsewhere

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (div_valid_i) begin
          state_d = prep_i.special ? FINISH : DO_DIV;
        end
      end
      DO_DIV: begin
        if (cnt_q == '0) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        if (result_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign load_o = accept && !prep_i.special;
  assign step_o = (state_q == DO_DIV) && (cnt_q != '0);

  // only the fields needed after accept are kept
  always_comb begin
    held_d                = '0;
    held_d.quo_neg        = prep_i.quo_neg;
    held_d.rem_neg        = prep_i.rem_neg;
    held_d.is_rem         = prep_i.is_rem;
    held_d.is_word        = prep_i.is_word;
    held_d.special        = prep_i.special;
    held_d.special_result = prep_i.special_result;
  end

  // ==========================================================================
  // registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (load_o) begin
        cnt_q <= prep_i.steps;
      end else if (step_o) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
      if (accept && prep_i.special) begin
        result_q <= prep_i.special_result;     // shortcut, no iteration
      end else if ((state_q == DO_DIV) && (state_d == FINISH)) begin
        result_q <= fix_result_i;
      end else if ((state_q == FINISH) && (state_d == IDLE)) begin
        result_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_q <= held_d;
    end
  end

  assign held_o      = held_q;
  assign result_o    = result_q;
  assign result_ok_o = (state_q == FINISH);
  assign busy_o      = load_o || (state_q == DO_DIV);

  a_ok_busy_excl: assert property (
    @(posedge clk) disable iff (rst_n) !(result_ok_o && busy_o)
  ) else $error("div result_ok and busy high together");

  // remaining count never exceeds the step count of the held op
  a_step_in_div: assert property (
    @(posedge clk) disable iff (rst_n)
    step_o |-> (cnt_q <= (held_q.is_word ? cnt_t'(`DIV_STEPS_W) : cnt_t'(`DIV_STEPS_D)))
  ) else $error("div step count exceeds the steps of the held op");

endmodule

// File: div_defs.svh
// ==========================================================================
// width and step count macros for the integer divide unit
// ==========================================================================
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// ==========================================================================
// datapath widths
// ==========================================================================
`define DIV_XLEN 64   // register width
`define DIV_WLEN 32   // width of the *w operations

// ==========================================================================
// iteration control
// ==========================================================================
`define DIV_CNT_W 7   // holds up to 64

// one quotient bit per step
`define DIV_STEPS_D 64
`define DIV_STEPS_W 32

`endif

// File: div_iter_unit.sv
// ==========================================================================
// restoring shift-subtract core: remainder/quotient register and divisor,
// one quotient bit per step
// ==========================================================================
`timescale 1ns/1ps
`include "div_defs.svh"

module div_iter_unit
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_i,
  input  logic      step_i,
  input  xlen_t     quo_init_i,
  input  xlen_t     divisor_i,
  output div_iter_t iter_o
);

  div_iter_t                iter_q;
  div_iter_t                iter_d;
  xlen_t                    divisor_q;
  logic [`DIV_XLEN:0]       partial;   // shifted remainder, carry kept
  logic [`DIV_XLEN:0]       diff;
  logic                     fits;

  // ==========================================================================
  // one step
  // ==========================================================================
  assign partial = {iter_q.rem, iter_q.quo[`DIV_XLEN-1]};
  assign diff    = partial - {1'b0, divisor_q};
  assign fits    = ~diff[`DIV_XLEN];          // non-negative difference

  always_comb begin
    iter_d = iter_q;
    if (load_i) begin
      iter_d.rem = '0;
      iter_d.quo = quo_init_i;
    end else if (step_i) begin
      if (fits) begin
        iter_d.rem = diff[`DIV_XLEN-1:0];
        iter_d.quo = {iter_q.quo[`DIV_XLEN-2:0], 1'b1};
      end else begin
        iter_d.rem = partial[`DIV_XLEN-1:0];  // restore
        iter_d.quo = {iter_q.quo[`DIV_XLEN-2:0], 1'b0};
      end
    end
  end

  // ==========================================================================
  // registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    iter_q <= iter_d;
    if (load_i) begin
      divisor_q <= divisor_i;                 // held for the whole division
    end
  end

  assign iter_o = iter_q;

  // the control FSM never loads while a division is running
  a_load_step_excl: assert property (
    @(posedge clk) disable iff (rst_n) !(load_i && step_i)
  ) else $error("div iter unit got load and step together");

endmodule

// File: div_operand_prep.sv
// ==========================================================================
// request decode: operand extension and magnitudes, sign flags, and the
// zero divisor / overflow / illegal op shortcuts
// ==========================================================================
`timescale 1ns/1ps
`include "div_defs.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  div_req_t  req_i,
  output div_prep_t prep_o
);

  localparam int HI_W = `DIV_XLEN - `DIV_WLEN;

  logic  is_signed;
  logic  is_word;
  logic  is_rem;
  logic  is_legal;
  xlen_t a_sext;
  xlen_t b_sext;
  xlen_t a_ext;
  xlen_t b_ext;
  xlen_t a_mag;
  xlen_t b_mag;
  xlen_t int_min;
  logic  a_neg;
  logic  b_neg;
  logic  div_zero;
  logic  overflow;

  // ==========================================================================
  // decode and extension
  // ==========================================================================
  assign is_signed = req_i.op inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  assign is_word   = req_i.op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign is_rem    = req_i.op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  assign is_legal  = req_i.op inside {OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                                      OP_REM, OP_REMU, OP_REMUW, OP_REMW};

  assign a_sext = {{HI_W{req_i.dividend[`DIV_WLEN-1]}}, req_i.dividend[`DIV_WLEN-1:0]};
  assign b_sext = {{HI_W{req_i.divisor[`DIV_WLEN-1]}}, req_i.divisor[`DIV_WLEN-1:0]};

  always_comb begin
    if (!is_word) begin
      a_ext = req_i.dividend;
      b_ext = req_i.divisor;
    end else if (is_signed) begin
      a_ext = a_sext;
      b_ext = b_sext;
    end else begin
      a_ext = {{HI_W{1'b0}}, req_i.dividend[`DIV_WLEN-1:0]};
      b_ext = {{HI_W{1'b0}}, req_i.divisor[`DIV_WLEN-1:0]};
    end
  end

  assign a_neg = is_signed & a_ext[`DIV_XLEN-1];
  assign b_neg = is_signed & b_ext[`DIV_XLEN-1];
  assign a_mag = a_neg ? (~a_ext + xlen_t'(1)) : a_ext;
  assign b_mag = b_neg ? (~b_ext + xlen_t'(1)) : b_ext;

  // most negative value, after extension
  assign int_min = is_word ? {{(HI_W+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}}
                           : {1'b1, {(`DIV_XLEN-1){1'b0}}};

  assign div_zero = (b_ext == '0);
  assign overflow = is_signed && (a_ext == int_min) && (b_ext == '1);

  // ==========================================================================
  // prepared operands
  // ==========================================================================
  always_comb begin
    prep_o.quo_init    = is_word ? {a_mag[`DIV_WLEN-1:0], {HI_W{1'b0}}} : a_mag;
    prep_o.divisor_mag = b_mag;
    prep_o.quo_neg     = a_neg ^ b_neg;
    prep_o.rem_neg     = a_neg;                 // remainder follows dividend
    prep_o.is_rem      = is_rem;
    prep_o.is_word     = is_word;
    prep_o.steps       = is_word ? cnt_t'(`DIV_STEPS_W) : cnt_t'(`DIV_STEPS_D);
    prep_o.special     = !is_legal || div_zero || overflow;
    if (!is_legal) begin
      prep_o.special_result = '0;
    end else if (div_zero) begin
      prep_o.special_result = is_rem ? (is_word ? a_sext : req_i.dividend) : '1;
    end else if (overflow) begin
      prep_o.special_result = is_rem ? '0 : a_ext;
    end else begin
      prep_o.special_result = '0;
    end
  end

  // decode hands over one-hot codes or nothing at all
  always_comb begin
    assert final ($isunknown(req_i.op) || $onehot0(req_i.op))
      else $error("div op code %b has more than one bit set", req_i.op);
  end

endmodule

// File: div_pkg.sv
// ==========================================================================
// divide unit types: data words, op codes, FSM states, request and
// operand bundles, iteration register layout
// ==========================================================================
`include "div_defs.svh"

package div_pkg;

  typedef logic [`DIV_XLEN-1:0]  xlen_t;
  typedef logic [`DIV_CNT_W-1:0] cnt_t;
  typedef logic [7:0]            div_op_t;

  // one-hot op codes as issued by decode
  localparam div_op_t OP_DIV   = 8'b1000_0000;
  localparam div_op_t OP_DIVU  = 8'b0100_0000;
  localparam div_op_t OP_DIVUW = 8'b0010_0000;
  localparam div_op_t OP_DIVW  = 8'b0001_0000;
  localparam div_op_t OP_REM   = 8'b0000_1000;
  localparam div_op_t OP_REMU  = 8'b0000_0100;
  localparam div_op_t OP_REMUW = 8'b0000_0010;
  localparam div_op_t OP_REMW  = 8'b0000_0001;

  typedef enum logic [1:0] {
    IDLE,
    DO_DIV,
    FINISH
  } div_state_e;

  typedef struct packed {
    div_op_t op;
    xlen_t   dividend;
    xlen_t   divisor;
  } div_req_t;

  typedef struct packed {
    xlen_t quo_init;        // low half of the iteration register
    xlen_t divisor_mag;
    logic  quo_neg;         // negate quotient at the end
    logic  rem_neg;         // negate remainder at the end
    logic  is_rem;
    logic  is_word;
    cnt_t  steps;
    logic  special;         // finishes without iterating
    xlen_t special_result;
  } div_prep_t;

  typedef struct packed {
    xlen_t rem;             // upper half, partial remainder
    xlen_t quo;             // lower half, dividend bits out, quotient bits in
  } div_iter_t;

endpackage

// File: div_result_fix.sv
// ==========================================================================
// result selection: quotient or remainder, sign restore, word extension
// ==========================================================================
`timescale 1ns/1ps
`include "div_defs.svh"

module div_result_fix
  import div_pkg::*;
(
  input  div_iter_t iter_i,
  input  div_prep_t held_i,
  output xlen_t     result_o
);

  localparam int HI_W = `DIV_XLEN - `DIV_WLEN;

  xlen_t sel;
  xlen_t signed_val;
  logic  neg;

  // word ops leave the quotient in the low 32 bits of quo
  assign sel = held_i.is_rem ? iter_i.rem : iter_i.quo;
  assign neg = held_i.is_rem ? held_i.rem_neg : held_i.quo_neg;

  assign signed_val = neg ? (~sel + xlen_t'(1)) : sel;

  always_comb begin
    if (held_i.is_word) begin
      result_o = {{HI_W{signed_val[`DIV_WLEN-1]}}, signed_val[`DIV_WLEN-1:0]};
    end else begin
      result_o = signed_val;
    end
  end

endmodule

// File: div_unit_top.sv
// ==========================================================================
// integer divide unit top: operand prep, control FSM, iteration core and
// result fix-up
// ==========================================================================
`timescale 1ns/1ps

module div_unit_top
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_t div_type_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    result_ready_i,
  output xlen_t   result_o,
  output logic    busy_o,
  output logic    result_ok_o
);

  div_req_t  req;
  div_prep_t prep;
  div_prep_t held;
  div_iter_t iter;
  xlen_t     fix_result;
  logic      load;
  logic      step;

  assign req = '{op: div_type_i, dividend: dividend_i, divisor: divisor_i};

  div_operand_prep prep_i (
    .req_i  (req),
    .prep_o (prep)
  );

  div_ctrl ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .result_ready_i (result_ready_i),
    .prep_i         (prep),
    .fix_result_i   (fix_result),
    .load_o         (load),
    .step_o         (step),
    .held_o         (held),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .busy_o         (busy_o)
  );

  div_iter_unit iter_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load),
    .step_i     (step),
    .quo_init_i (prep.quo_init),
    .divisor_i  (prep.divisor_mag),
    .iter_o     (iter)
  );

  div_result_fix fix_i (
    .iter_i   (iter),
    .held_i   (held),
    .result_o (fix_result)
  );

endmodule

// File: sim.f
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_iter_unit.sv
div_result_fix.sv
div_ctrl.sv
div_unit_top.sv
tb_div_unit.sv

// File: tb_div_model.svh
// ==========================================================================
// testbench helpers: xorshift generator, ISA reference model for the eight
// divide ops, typed compare tasks
// ==========================================================================
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

int    err_cnt   = 0;
xlen_t rng_state = 64'd51274;

// ==========================================================================
// stimulus helpers
// ==========================================================================
function automatic xlen_t next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 7);
  rng_state = rng_state ^ (rng_state << 17);
  return rng_state;
endfunction

// random upper half, the *w ops must ignore it
function automatic xlen_t with_garbage(input logic [31:0] lo);
  xlen_t r;
  r = next_rand();
  return {r[63:32], lo};
endfunction

// ==========================================================================
// reference model
// ==========================================================================
function automatic xlen_t model_op(input div_op_t op, input xlen_t a, input xlen_t b);
  logic               sgn;
  logic               word;
  logic               rem;
  xlen_t              x;
  xlen_t              y;
  xlen_t              q;
  xlen_t              r;
  xlen_t              min_val;
  logic signed [63:0] sx;
  logic signed [63:0] sy;
  xlen_t              res;
  if (!(op inside {OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW, OP_REM, OP_REMU, OP_REMUW, OP_REMW})) begin
    return '0;                                   // illegal op code
  end
  sgn  = op inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  word = op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  rem  = op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  x = a;
  y = b;
  min_val = 64'h8000_0000_0000_0000;
  if (word) begin
    x = sgn ? {{32{a[31]}}, a[31:0]} : {32'h0, a[31:0]};
    y = sgn ? {{32{b[31]}}, b[31:0]} : {32'h0, b[31:0]};
    min_val = 64'hFFFF_FFFF_8000_0000;
  end
  sx = x;
  sy = y;
  if (y == '0) begin
    q = '1;                                      // divide by zero
    r = x;
  end else if (sgn && (x == min_val) && (y == '1)) begin
    q = x;                                       // signed overflow
    r = '0;
  end else if (sgn) begin
    q = sx / sy;                                 // truncates toward zero
    r = sx % sy;
  end else begin
    q = x / y;
    r = x % y;
  end
  res = rem ? r : q;
  if (word) begin
    res = {{32{res[31]}}, res[31:0]};
  end
  return res;
endfunction

// ==========================================================================
// compare tasks
// ==========================================================================
task automatic check_result(input string name, input xlen_t got, input xlen_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_latency(input cnt_t got, input cnt_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t latency: got %0d, expected %0d", $time, got, exp);
    err_cnt++;
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    err_cnt++;
  end
endtask

`endif

// File: tb_div_unit.sv
// ==========================================================================
// divide unit testbench: clock, reset, watchdog and directed tests
// ==========================================================================
`timescale 1ns/1ps
`include "div_defs.svh"

module tb_div_unit
  import div_pkg::*;
();

  localparam int      CLK_PERIOD = 4;
  localparam realtime DRIVE_DLY  = 0.5;
  localparam int      OP_BUDGET  = 2000;
  localparam int      OP_CYCLES  = 70;
  localparam int      WAIT_LIMIT = 100;
  localparam cnt_t    LAT_D      = cnt_t'(`DIV_STEPS_D + 2);
  localparam cnt_t    LAT_W      = cnt_t'(`DIV_STEPS_W + 2);
  localparam cnt_t    LAT_S      = cnt_t'(1);

  logic    clk;
  logic    rst_n;
  logic    div_valid;
  div_op_t div_type;
  xlen_t   dividend;
  xlen_t   divisor;
  logic    result_ready;
  xlen_t   result;
  logic    busy;
  logic    result_ok;

  `include "tb_div_model.svh"

  div_unit_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid),
    .div_type_i     (div_type),
    .dividend_i     (dividend),
    .divisor_i      (divisor),
    .result_ready_i (result_ready),
    .result_o       (result),
    .busy_o         (busy),
    .result_ok_o    (result_ok)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(OP_BUDGET * OP_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  // ==========================================================================
  // one request: issue, wait for done, hold off ready, release
  // ==========================================================================
  task automatic run_op(input div_op_t op, input xlen_t a, input xlen_t b,
                        input cnt_t exp_lat, input int hold);
    xlen_t exp_res;
    int    lat;
    exp_res   = model_op(op, a, b);
    div_valid = 1'b1;
    div_type  = op;
    dividend  = a;
    divisor   = b;
    @(negedge clk);
    compare_flag("busy_o", busy, exp_lat != LAT_S);   // stall only for iterating ops
    lat = 0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
      div_valid = 1'b0;
      lat++;
      @(negedge clk);
      if (!result_ok) begin
        compare_flag("busy_o", busy, exp_lat != LAT_S);
        check_result("result_o", result, '0);
      end
    end while (!result_ok && lat < WAIT_LIMIT);
    if (!result_ok) begin
      $display("%0t: result_ok_o never rose for op %b within %0d cycles",
               $time, op, WAIT_LIMIT);
      err_cnt++;
    end
    check_latency(cnt_t'(lat), exp_lat);
    check_result("result_o", result, exp_res);
    compare_flag("busy_o", busy, 1'b0);
    repeat (hold) begin
      @(posedge clk);
      #DRIVE_DLY;
      div_valid = 1'b1;                              // ignored outside IDLE
      div_type  = OP_DIVU;
      dividend  = next_rand();
      divisor   = next_rand();
      @(negedge clk);
      compare_flag("result_ok_o", result_ok, 1'b1);
      check_result("result_o", result, exp_res);
    end
    @(posedge clk);
    #DRIVE_DLY;
    div_valid    = 1'b0;
    result_ready = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    result_ready = 1'b0;
    compare_flag("result_ok_o", result_ok, 1'b0);    // back in IDLE
    compare_flag("busy_o", busy, 1'b0);
    check_result("result_o", result, '0);
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic reset_values();
    compare_flag("result_ok_o", result_ok, 1'b0);
    compare_flag("busy_o", busy, 1'b0);
    check_result("result_o", result, '0);
  endtask

  task automatic unsigned_divides();
    xlen_t r;
    xlen_t b;
    run_op(OP_DIVU, 64'd1000, 64'd7, LAT_D, 0);
    run_op(OP_REMU, 64'd1000, 64'd7, LAT_D, 0);
    run_op(OP_DIVU, '1, 64'd3, LAT_D, 0);
    run_op(OP_REMU, 64'hFEDC_BA98_7654_3210, 64'h1_0000_0001, LAT_D, 0);
    run_op(OP_DIVU, 64'd5, 64'd9, LAT_D, 0);        // quotient zero
    for (int i = 0; i < 10; i++) begin
      r = next_rand();
      b = next_rand() >> r[5:0];
      if (b == '0) begin
        b = 64'd1;
      end
      run_op(OP_DIVU, r, b, LAT_D, 0);
      run_op(OP_REMU, r, b, LAT_D, 0);
    end
  endtask

  task automatic signed_divides();
    xlen_t a;
    xlen_t b;
    xlen_t r;
    for (int sa = 0; sa < 2; sa++) begin
      for (int sb = 0; sb < 2; sb++) begin
        a = (sa != 0) ? -64'd1234567 : 64'd1234567;
        b = (sb != 0) ? -64'd789 : 64'd789;
        run_op(OP_DIV, a, b, LAT_D, 0);
        run_op(OP_REM, a, b, LAT_D, 0);
      end
    end
    run_op(OP_DIV, -64'd21, 64'd7, LAT_D, 0);       // exact, remainder zero
    run_op(OP_DIV, 64'h8000_0000_0000_0000, 64'd2, LAT_D, 0);
    for (int i = 0; i < 6; i++) begin
      a = next_rand();
      r = next_rand();
      b = next_rand() >> r[5:0];
      if (r[6]) begin
        b = -b;
      end
      if (b == '0) begin
        b = 64'd3;
      end
      run_op(OP_DIV, a, b, LAT_D, 0);
      run_op(OP_REM, a, b, LAT_D, 0);
    end
  endtask

  task automatic word_divides();
    div_op_t     ops[4] = '{OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    xlen_t       r;
    logic [31:0] lo;
    for (int k = 0; k < 4; k++) begin
      run_op(ops[k], with_garbage(32'hFFFF_FF9C), with_garbage(32'd7), LAT_W, 0);
      run_op(ops[k], with_garbage(32'd100), with_garbage(32'hFFFF_FFF9), LAT_W, 0);
      for (int i = 0; i < 3; i++) begin
        r  = next_rand();
        lo = r[63:32] >> r[4:0];
        if (lo == '0) begin
          lo = 32'd1;
        end
        run_op(ops[k], with_garbage(r[31:0]), with_garbage(lo), LAT_W, 0);
      end
    end
  endtask

  task automatic special_cases();
    div_op_t all_ops[8] = '{OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                            OP_REM, OP_REMU, OP_REMUW, OP_REMW};
    for (int k = 0; k < 8; k++) begin
      run_op(all_ops[k], 64'h8000_0000_8765_4321, '0, LAT_S, 0);
      if (all_ops[k] inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
        run_op(all_ops[k], with_garbage(32'h8765_4321), with_garbage(32'h0), LAT_S, 0);
      end
    end
    run_op(OP_DIV, 64'h8000_0000_0000_0000, '1, LAT_S, 0);
    run_op(OP_REM, 64'h8000_0000_0000_0000, '1, LAT_S, 0);
    run_op(OP_DIVW, with_garbage(32'h8000_0000), with_garbage(32'hFFFF_FFFF), LAT_S, 0);
    run_op(OP_REMW, with_garbage(32'h8000_0000), with_garbage(32'hFFFF_FFFF), LAT_S, 0);
    run_op(8'h00, 64'd100, 64'd5, LAT_S, 0);        // no op bit set
  endtask

  task automatic backpressure_hold();
    xlen_t r;
    int    hold;
    for (int i = 0; i < 6; i++) begin
      r    = next_rand();
      hold = int'(r[3:0]) + 1;
      if (i[0]) begin
        run_op(OP_REMUW, with_garbage(r[63:32]), with_garbage(32'd13), LAT_W, hold);
      end else begin
        run_op(OP_DIV, r, 64'd12345, LAT_D, hold);
      end
    end
    // back to back, each request issued in the first IDLE cycle
    run_op(OP_DIVU, next_rand(), 64'd977, LAT_D, 0);
    run_op(OP_REM, next_rand(), '0, LAT_S, 0);
    run_op(OP_REMW, with_garbage(32'h7FFF_FFFF), with_garbage(32'd10), LAT_W, 0);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst_n        = 1'b1;
    div_valid    = 1'b0;
    div_type     = '0;
    dividend     = '0;
    divisor      = '0;
    result_ready = 1'b0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    reset_values();
    unsigned_divides();
    signed_divides();
    word_divides();
    special_cases();
    backpressure_hold();
    $display("divide unit tests done, %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
